//--- src/soc_cfg.svh
// SoC configuration
// Bus widths, device map and register offsets of the peripheral subsystem
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

`define BUS_DATA_WIDTH       32
`define APB_ADDR_WIDTH       12  // Host address
`define APB_SLAVE_ADDR_WIDTH 8   // Offset inside one device

`define APB_DEV_COUNT 2
`define GPIO_IDX      0  // Device index and psel bit
`define TIMER_IDX     1

`define GPIO_WIDTH 8
`define IRQ_COUNT  2

// GPIO register map
`define GPIO_OUT_OFF      8'h00
`define GPIO_IN_OFF       8'h04
`define GPIO_IRQ_EN_OFF   8'h08
`define GPIO_IRQ_STAT_OFF 8'h0C

// Timer register map
`define TIMER_CTRL_OFF  8'h00
`define TIMER_LOAD_OFF  8'h04
`define TIMER_COUNT_OFF 8'h08
`define TIMER_STAT_OFF  8'h0C

`endif

//--- src/soc_pkg.sv
// SoC types
// Vector types for the host port, APB and interrupt paths, and the bridge FSM states
`default_nettype none

`include "soc_cfg.svh"

package soc_pkg;

    typedef logic [`BUS_DATA_WIDTH-1:0]       data_t;
    typedef logic [`APB_ADDR_WIDTH-1:0]       addr_t;
    typedef logic [`APB_SLAVE_ADDR_WIDTH-1:0] reg_off_t;
    typedef logic [`APB_DEV_COUNT-1:0]        dev_sel_t;  // One-hot device select
    typedef logic [`GPIO_WIDTH-1:0]           gpio_t;
    typedef logic [`IRQ_COUNT-1:0]            irq_vec_t;
    typedef logic [7:0]                       irq_id_t;

    // Bridge transfer phases
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SETUP,
        ST_ACCESS,
        ST_DONE
    } bridge_state_t;

endpackage

`default_nettype wire

//--- src/irq_ctrl.sv
// Interrupt controller
// Registers the request line and a fixed-priority id of the pending sources.
// The lowest set bit of the vector wins
`default_nettype none

`include "soc_cfg.svh"

module irq_ctrl
    import soc_pkg::*;
(
    input  wire      clk,
    input  wire      rst_i,
    input  irq_vec_t irq_vec_i,
    output logic     irq_req_o,
    output irq_id_t  irq_id_o
);

    irq_id_t id_next;

    // Scan from the top so the lowest index is assigned last
    always_comb begin
        id_next = irq_id_o;  // Hold when idle
        for (int i = `IRQ_COUNT - 1; i >= 0; i--) begin
            if (irq_vec_i[i]) begin
                id_next = irq_id_t'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            irq_req_o <= 1'b0;
            irq_id_o  <= '0;
        end else begin
            irq_req_o <= |irq_vec_i;
            irq_id_o  <= id_next;
        end
    end

endmodule

`default_nettype wire

//--- src/host_apb_bridge.sv
// Host to APB bridge
// Turns one four-phase req/ack transfer into a single APB SETUP/ACCESS pair.
// The address bits above the register offset select the device; an index out
// of range is answered at once with an error and no bus access
`default_nettype none

`include "soc_cfg.svh"

module host_apb_bridge
    import soc_pkg::*;
(
    input  wire        clk,
    input  wire        rst_i,
    // Host side
    input  wire        host_req_i,
    input  wire        host_we_i,
    input  wire addr_t host_addr_i,
    input  wire data_t host_wdata_i,
    output logic       host_ack_o,
    output data_t      host_rdata_o,
    output logic       host_err_o,
    // APB master
    output dev_sel_t   psel_o,
    output logic       penable_o,
    output reg_off_t   paddr_o,
    output logic       pwrite_o,
    output data_t      pwdata_o,
    input  wire data_t gpio_prdata_i,
    input  wire        gpio_pslverr_i,
    input  wire data_t timer_prdata_i,
    input  wire        timer_pslverr_i
);

    localparam int DevIdxW = `APB_ADDR_WIDTH - `APB_SLAVE_ADDR_WIDTH;

    bridge_state_t      state, state_next;
    logic [DevIdxW-1:0] dev_idx;
    logic               dev_bad;
    logic               start;
    dev_sel_t           sel_q;
    reg_off_t           off_q;
    logic               we_q;
    data_t              wdata_q;
    data_t              rdata_q;
    logic               err_q;
    data_t              mux_rdata;
    logic               mux_err;

    assign dev_idx = host_addr_i[`APB_ADDR_WIDTH-1:`APB_SLAVE_ADDR_WIDTH];
    assign dev_bad = dev_idx >= `APB_DEV_COUNT;
    assign start   = (state == ST_IDLE) && host_req_i;

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (host_req_i) begin
                    state_next = dev_bad ? ST_DONE : ST_SETUP;
                end
            end
            ST_SETUP:  state_next = ST_ACCESS;
            ST_ACCESS: state_next = ST_DONE;
            ST_DONE: begin
                if (!host_req_i) begin
                    state_next = ST_IDLE;  // Four-phase release
                end
            end
            default:   state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Request latch, stable for the whole transfer
    always_ff @(posedge clk) begin
        if (start) begin
            sel_q   <= dev_sel_t'(1) << dev_idx;
            off_q   <= host_addr_i[`APB_SLAVE_ADDR_WIDTH-1:0];
            we_q    <= host_we_i;
            wdata_q <= host_wdata_i;
        end
    end

    // Read return from the selected device
    always_comb begin
        mux_rdata = '0;
        mux_err   = 1'b0;
        if (sel_q[`GPIO_IDX]) begin
            mux_rdata = gpio_prdata_i;
            mux_err   = gpio_pslverr_i;
        end
        if (sel_q[`TIMER_IDX]) begin
            mux_rdata = timer_prdata_i;
            mux_err   = timer_pslverr_i;
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_ACCESS) begin
            rdata_q <= mux_rdata;
        end else if (start && dev_bad) begin
            rdata_q <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            err_q <= 1'b0;
        end else if (state == ST_ACCESS) begin
            err_q <= mux_err;
        end else if (start) begin
            err_q <= dev_bad;  // Decode error
        end
    end

    assign psel_o       = (state == ST_SETUP || state == ST_ACCESS) ? sel_q : '0;
    assign penable_o    = state == ST_ACCESS;
    assign paddr_o      = off_q;
    assign pwrite_o     = we_q;
    assign pwdata_o     = wdata_q;
    assign host_ack_o   = state == ST_DONE;
    assign host_rdata_o = rdata_q;
    assign host_err_o   = err_q;

endmodule

`default_nettype wire

//--- src/apb_gpio.sv
// APB GPIO
// Output register, two-flop input synchronizer and rising-edge interrupts.
// IRQ_STAT bits are cleared by writing ones
`default_nettype none

`include "soc_cfg.svh"

module apb_gpio
    import soc_pkg::*;
(
    input  wire           clk,
    input  wire           rst_i,
    input  wire           psel_i,
    input  wire           penable_i,
    input  wire reg_off_t paddr_i,
    input  wire           pwrite_i,
    input  wire data_t    pwdata_i,
    output data_t         prdata_o,
    output logic          pslverr_o,
    input  wire gpio_t    gpio_in_i,
    output gpio_t         gpio_out_o,
    output logic          irq_o
);

    gpio_t out_q, irq_en_q, stat_q;
    gpio_t sync1_q, sync2_q, prev_q;
    gpio_t rise, stat_clr;
    logic  wr_en;

    assign wr_en    = psel_i & penable_i & pwrite_i;
    assign rise     = sync2_q & ~prev_q & irq_en_q;
    assign stat_clr = (wr_en && paddr_i == `GPIO_IRQ_STAT_OFF) ?
                      pwdata_i[`GPIO_WIDTH-1:0] : '0;

    always_comb begin
        prdata_o  = '0;
        pslverr_o = 1'b0;
        case (paddr_i)
            `GPIO_OUT_OFF:      prdata_o = data_t'(out_q);
            `GPIO_IN_OFF: begin
                prdata_o  = data_t'(sync2_q);
                pslverr_o = psel_i & pwrite_i;  // Read only
            end
            `GPIO_IRQ_EN_OFF:   prdata_o = data_t'(irq_en_q);
            `GPIO_IRQ_STAT_OFF: prdata_o = data_t'(stat_q);
            default:            pslverr_o = psel_i;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            out_q    <= '0;
            irq_en_q <= '0;
            stat_q   <= '0;
            sync1_q  <= '0;
            sync2_q  <= '0;
            prev_q   <= '0;
        end else begin
            sync1_q <= gpio_in_i;
            sync2_q <= sync1_q;
            prev_q  <= sync2_q;  // Edge reference
            stat_q  <= (stat_q & ~stat_clr) | rise;  // New edge beats clear
            if (wr_en && paddr_i == `GPIO_OUT_OFF) begin
                out_q <= pwdata_i[`GPIO_WIDTH-1:0];
            end
            if (wr_en && paddr_i == `GPIO_IRQ_EN_OFF) begin
                irq_en_q <= pwdata_i[`GPIO_WIDTH-1:0];
            end
        end
    end

    assign gpio_out_o = out_q;
    assign irq_o      = |stat_q;

endmodule

`default_nettype wire

//--- src/apb_timer.sv
// APB timer
// Down counter on clk with one-shot and auto-reload modes.
// CTRL bit 0 enables, bit 1 selects auto-reload; STAT bit 0 flags expiry
`default_nettype none

`include "soc_cfg.svh"

module apb_timer
    import soc_pkg::*;
(
    input  wire           clk,
    input  wire           rst_i,
    input  wire           psel_i,
    input  wire           penable_i,
    input  wire reg_off_t paddr_i,
    input  wire           pwrite_i,
    input  wire data_t    pwdata_i,
    output data_t         prdata_o,
    output logic          pslverr_o,
    output logic          irq_o
);

    logic  en_q, auto_q, expired_q;
    data_t load_q, count_q;
    logic  wr_en;
    logic  expire;
    logic  stat_clr;

    assign wr_en    = psel_i & penable_i & pwrite_i;
    assign expire   = en_q && (count_q == data_t'(1));  // Last decrement
    assign stat_clr = wr_en && paddr_i == `TIMER_STAT_OFF && pwdata_i[0];

    always_comb begin
        prdata_o  = '0;
        pslverr_o = 1'b0;
        case (paddr_i)
            `TIMER_CTRL_OFF:  prdata_o = data_t'({auto_q, en_q});
            `TIMER_LOAD_OFF:  prdata_o = load_q;
            `TIMER_COUNT_OFF: begin
                prdata_o  = count_q;
                pslverr_o = psel_i & pwrite_i;
            end
            `TIMER_STAT_OFF:  prdata_o = data_t'(expired_q);
            default:          pslverr_o = psel_i;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            en_q      <= 1'b0;
            auto_q    <= 1'b0;
            expired_q <= 1'b0;
            load_q    <= '0;
            count_q   <= '0;
        end else begin
            expired_q <= (expired_q & ~stat_clr) | expire;
            if (expire && !auto_q) begin
                en_q <= 1'b0;  // One-shot stops itself
            end
            if (wr_en && paddr_i == `TIMER_CTRL_OFF) begin
                en_q   <= pwdata_i[0];
                auto_q <= pwdata_i[1];
            end
            // A LOAD write restarts the count
            if (wr_en && paddr_i == `TIMER_LOAD_OFF) begin
                load_q  <= pwdata_i;
                count_q <= pwdata_i;
            end else if (expire) begin
                count_q <= auto_q ? load_q : '0;
            end else if (en_q && count_q != '0) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    assign irq_o = expired_q;

endmodule

`default_nettype wire

//--- src/soc_top.sv
// Peripheral subsystem top
// Host bridge, GPIO, timer and interrupt controller on a shared APB
`default_nettype none

`include "soc_cfg.svh"

module soc_top
    import soc_pkg::*;
(
    input  wire        clk,
    input  wire        rst_i,
    input  wire        host_req_i,
    input  wire        host_we_i,
    input  wire addr_t host_addr_i,
    input  wire data_t host_wdata_i,
    output logic       host_ack_o,
    output data_t      host_rdata_o,
    output logic       host_err_o,
    input  wire gpio_t gpio_in_i,
    output gpio_t      gpio_out_o,
    output logic       irq_req_o,
    output irq_id_t    irq_id_o
);

    dev_sel_t psel;
    logic     penable;
    reg_off_t paddr;
    logic     pwrite;
    data_t    pwdata;
    data_t    gpio_prdata, timer_prdata;
    logic     gpio_pslverr, timer_pslverr;
    logic     gpio_irq, timer_irq;
    irq_vec_t irq_vec;

    assign irq_vec = {gpio_irq, timer_irq};  // Timer first in priority

    host_apb_bridge u_bridge (
        .clk            (clk),
        .rst_i          (rst_i),
        .host_req_i     (host_req_i),
        .host_we_i      (host_we_i),
        .host_addr_i    (host_addr_i),
        .host_wdata_i   (host_wdata_i),
        .host_ack_o     (host_ack_o),
        .host_rdata_o   (host_rdata_o),
        .host_err_o     (host_err_o),
        .psel_o         (psel),
        .penable_o      (penable),
        .paddr_o        (paddr),
        .pwrite_o       (pwrite),
        .pwdata_o       (pwdata),
        .gpio_prdata_i  (gpio_prdata),
        .gpio_pslverr_i (gpio_pslverr),
        .timer_prdata_i (timer_prdata),
        .timer_pslverr_i(timer_pslverr)
    );

    apb_gpio u_gpio (
        .clk       (clk),
        .rst_i     (rst_i),
        .psel_i    (psel[`GPIO_IDX]),
        .penable_i (penable),
        .paddr_i   (paddr),
        .pwrite_i  (pwrite),
        .pwdata_i  (pwdata),
        .prdata_o  (gpio_prdata),
        .pslverr_o (gpio_pslverr),
        .gpio_in_i (gpio_in_i),
        .gpio_out_o(gpio_out_o),
        .irq_o     (gpio_irq)
    );

    apb_timer u_timer (
        .clk      (clk),
        .rst_i    (rst_i),
        .psel_i   (psel[`TIMER_IDX]),
        .penable_i(penable),
        .paddr_i  (paddr),
        .pwrite_i (pwrite),
        .pwdata_i (pwdata),
        .prdata_o (timer_prdata),
        .pslverr_o(timer_pslverr),
        .irq_o    (timer_irq)
    );

    irq_ctrl u_irq_ctrl (
        .clk      (clk),
        .rst_i    (rst_i),
        .irq_vec_i(irq_vec),
        .irq_req_o(irq_req_o),
        .irq_id_o (irq_id_o)
    );

endmodule

`default_nettype wire

//--- test/tb_clk_gen.sv
// Testbench clock and reset
// 20 ns clock, reset held high for the first 5 rising edges
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic rst_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (5) @(posedge clk_o);
        rst_o <= 1'b0;  // Released on the 5th edge
    end

endmodule

`default_nettype wire

//--- test/soc_sva.sv
// SoC protocol checker
// Concurrent assertions on the host four-phase handshake, the APB select
// lines and the interrupt id, bound into the SoC top
`default_nettype none

`include "soc_cfg.svh"

module soc_sva
    import soc_pkg::*;
(
    input wire           clk,
    input wire           rst_i,
    input wire           host_req_i,
    input wire addr_t    host_addr_i,
    input wire           host_ack_i,
    input wire dev_sel_t psel_i,
    input wire           penable_i,
    input wire           irq_req_i,
    input wire irq_id_t  irq_id_i
);
    timeunit 1ns;
    timeprecision 100ps;

    int   err_cnt = 0;  // Number of failed assertions
    logic dev_ok;

    assign dev_ok = host_addr_i[`APB_ADDR_WIDTH-1:`APB_SLAVE_ADDR_WIDTH] < `APB_DEV_COUNT;

    ack_needs_req: assert property (@(posedge clk) disable iff (rst_i)
        $rose(host_ack_i) |-> host_req_i)
        else begin
            $error("host_ack_o rose while host_req_i was low");
            err_cnt++;
        end

    // Release phase of the handshake
    ack_release: assert property (@(posedge clk) disable iff (rst_i)
        host_ack_i && !host_req_i |=> !host_ack_i)
        else begin
            $error("host_ack_o stayed high one cycle after host_req_i fell");
            err_cnt++;
        end

    ack_latency: assert property (@(posedge clk) disable iff (rst_i)
        $rose(host_req_i) && dev_ok |->
            !host_ack_i ##1 !host_ack_i ##1 !host_ack_i ##1 host_ack_i)
        else begin
            $error("host_ack_o not seen exactly 3 cycles after host_req_i");
            err_cnt++;
        end

    psel_onehot: assert property (@(posedge clk) disable iff (rst_i)
        $onehot0(psel_i))
        else begin
            $error("psel has more than one device selected");
            err_cnt++;
        end

    penable_with_psel: assert property (@(posedge clk) disable iff (rst_i)
        penable_i |-> |psel_i)
        else begin
            $error("penable high with no device selected");
            err_cnt++;
        end

    irq_id_range: assert property (@(posedge clk) disable iff (rst_i)
        irq_req_i |-> irq_id_i < `IRQ_COUNT)
        else begin
            $error("irq_id_o out of range while irq_req_o is high");
            err_cnt++;
        end

endmodule

bind soc_top soc_sva u_sva (
    .clk        (clk),
    .rst_i      (rst_i),
    .host_req_i (host_req_i),
    .host_addr_i(host_addr_i),
    .host_ack_i (host_ack_o),
    .psel_i     (psel),
    .penable_i  (penable),
    .irq_req_i  (irq_req_o),
    .irq_id_i   (irq_id_o)
);

`default_nettype wire

//--- test/soc_tb.sv
// SoC testbench
// Host transfers to the GPIO and timer, pin stimulus and interrupt checks.
// Read data and errors are compared with a small register model
`default_nettype none

`include "soc_cfg.svh"

module soc_tb
    import soc_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT_CYCLES = 3000;  // Tests need well under half

    logic    clk, rst;
    logic    host_req, host_we;
    addr_t   host_addr;
    data_t   host_wdata, host_rdata;
    logic    host_ack, host_err;
    gpio_t   gpio_in, gpio_out;
    logic    irq_req;
    irq_id_t irq_id;

    int      seed = 75848;
    int      cycle_cnt = 0;
    data_t   rdata, wdata;
    logic    err;
    gpio_t   m_out, m_en;  // Register model
    data_t   m_load;

    tb_clk_gen u_clk_gen (.clk_o(clk), .rst_o(rst));

    soc_top u_dut (
        .clk         (clk),
        .rst_i       (rst),
        .host_req_i  (host_req),
        .host_we_i   (host_we),
        .host_addr_i (host_addr),
        .host_wdata_i(host_wdata),
        .host_ack_o  (host_ack),
        .host_rdata_o(host_rdata),
        .host_err_o  (host_err),
        .gpio_in_i   (gpio_in),
        .gpio_out_o  (gpio_out),
        .irq_req_o   (irq_req),
        .irq_id_o    (irq_id)
    );

    function automatic addr_t gpio_addr(input reg_off_t off);
        return addr_t'(`GPIO_IDX << `APB_SLAVE_ADDR_WIDTH) | addr_t'(off);
    endfunction

    function automatic addr_t timer_addr(input reg_off_t off);
        return addr_t'(`TIMER_IDX << `APB_SLAVE_ADDR_WIDTH) | addr_t'(off);
    endfunction

    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_eq(input string name, input data_t exp, input data_t act);
        assert (act === exp) else begin
            $display("[FAIL] %0d ns: %s expected 0x%08h, got 0x%08h", $time, name, exp, act);
            abort_run();
        end
    endtask

    // One four-phase transfer that returns once ack has dropped
    task automatic host_xfer(input logic we, input addr_t addr, input data_t wd,
                             output data_t rd, output logic er);
        @(posedge clk);
        host_req   <= 1'b1;
        host_we    <= we;
        host_addr  <= addr;
        host_wdata <= wd;
        @(posedge clk);
        while (host_ack !== 1'b1) @(posedge clk);
        rd = host_rdata;
        er = host_err;
        host_req <= 1'b0;
        while (host_ack !== 1'b0) @(posedge clk);
    endtask

    task automatic write_ok(input addr_t addr, input data_t wd);
        data_t rd;
        logic  er;
        host_xfer(1'b1, addr, wd, rd, er);
        check_eq("host_err_o", 32'd0, data_t'(er));
    endtask

    task automatic read_check(input addr_t addr, input data_t exp, input string name);
        data_t rd;
        logic  er;
        host_xfer(1'b0, addr, '0, rd, er);
        check_eq("host_err_o", 32'd0, data_t'(er));
        check_eq(name, exp, rd);
    endtask

    task automatic expect_err(input logic we, input addr_t addr, input data_t wd);
        data_t rd;
        logic  er;
        host_xfer(we, addr, wd, rd, er);
        check_eq("host_err_o", 32'd1, data_t'(er));
    endtask

    task automatic wait_irq_req(input logic level);
        while (irq_req !== level) @(posedge clk);
    endtask

    task automatic wait_irq_id(input irq_id_t id);
        while (irq_id !== id) @(posedge clk);
    endtask

    // Timeout and assertion monitor
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end else if (u_dut.u_sva.err_cnt != 0) begin
            $display("A protocol assertion in soc_sva failed");
            abort_run();
        end
    end

    initial begin
        host_req   = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        gpio_in    = '0;
        m_out      = '0;
        m_en       = '0;
        m_load     = '0;
        while (rst !== 1'b0) @(posedge clk);
        check_eq("gpio_out_o", 32'd0, data_t'(gpio_out));
        check_eq("irq_req_o", 32'd0, data_t'(irq_req));

        // GPIO output with random data
        for (int i = 0; i < 8; i++) begin
            wdata = $random(seed);
            write_ok(gpio_addr(`GPIO_OUT_OFF), wdata);
            m_out = wdata[`GPIO_WIDTH-1:0];
            check_eq("gpio_out_o", data_t'(m_out), data_t'(gpio_out));
            read_check(gpio_addr(`GPIO_OUT_OFF), data_t'(m_out), "GPIO OUT");
        end

        // Edge interrupt with bit 6 rising while masked
        m_en = 8'h0F;
        write_ok(gpio_addr(`GPIO_IRQ_EN_OFF), data_t'(m_en));
        read_check(gpio_addr(`GPIO_IRQ_EN_OFF), data_t'(m_en), "GPIO IRQ_EN");
        @(posedge clk);
        gpio_in <= 8'h44;
        wait_irq_req(1'b1);
        check_eq("irq_id_o", 32'd1, data_t'(irq_id));
        read_check(gpio_addr(`GPIO_IN_OFF), 32'h44, "GPIO IN");
        read_check(gpio_addr(`GPIO_IRQ_STAT_OFF), data_t'(8'h44 & m_en), "GPIO IRQ_STAT");
        write_ok(gpio_addr(`GPIO_IRQ_STAT_OFF), 32'h04);
        wait_irq_req(1'b0);
        read_check(gpio_addr(`GPIO_IRQ_STAT_OFF), 32'd0, "GPIO IRQ_STAT");

        // One-shot timer
        m_load = 32'd5;
        write_ok(timer_addr(`TIMER_LOAD_OFF), m_load);
        write_ok(timer_addr(`TIMER_CTRL_OFF), 32'h1);
        wait_irq_req(1'b1);
        check_eq("irq_id_o", 32'd0, data_t'(irq_id));
        read_check(timer_addr(`TIMER_COUNT_OFF), 32'd0, "timer COUNT");
        read_check(timer_addr(`TIMER_CTRL_OFF), 32'd0, "timer CTRL");
        read_check(timer_addr(`TIMER_STAT_OFF), 32'd1, "timer STAT");
        read_check(timer_addr(`TIMER_LOAD_OFF), m_load, "timer LOAD");
        write_ok(timer_addr(`TIMER_STAT_OFF), 32'h1);
        wait_irq_req(1'b0);

        // Auto-reload with a period long enough to clear before the next expiry
        m_load = 32'd60;
        write_ok(timer_addr(`TIMER_LOAD_OFF), m_load);
        write_ok(timer_addr(`TIMER_CTRL_OFF), 32'h3);
        wait_irq_req(1'b1);
        check_eq("irq_id_o", 32'd0, data_t'(irq_id));
        host_xfer(1'b0, timer_addr(`TIMER_COUNT_OFF), '0, rdata, err);
        check_eq("host_err_o", 32'd0, data_t'(err));
        assert (rdata != '0 && rdata <= m_load) else begin
            $display("[FAIL] %0d ns: timer COUNT expected 1 to 0x%08h, got 0x%08h",
                     $time, m_load, rdata);
            abort_run();
        end
        read_check(timer_addr(`TIMER_CTRL_OFF), 32'h3, "timer CTRL");
        write_ok(timer_addr(`TIMER_STAT_OFF), 32'h1);
        wait_irq_req(1'b0);
        write_ok(timer_addr(`TIMER_CTRL_OFF), 32'h0);
        read_check(timer_addr(`TIMER_STAT_OFF), 32'd0, "timer STAT");

        // Timer wins over GPIO in priority
        @(posedge clk);
        gpio_in <= 8'h00;
        repeat (4) @(posedge clk);  // Let the edge register settle
        gpio_in <= 8'h01;
        wait_irq_req(1'b1);
        check_eq("irq_id_o", 32'd1, data_t'(irq_id));
        m_load = 32'd4;
        write_ok(timer_addr(`TIMER_LOAD_OFF), m_load);
        write_ok(timer_addr(`TIMER_CTRL_OFF), 32'h1);
        wait_irq_id(8'd0);
        check_eq("irq_req_o", 32'd1, data_t'(irq_req));
        read_check(timer_addr(`TIMER_STAT_OFF), 32'd1, "timer STAT");
        read_check(gpio_addr(`GPIO_IRQ_STAT_OFF), 32'h01, "GPIO IRQ_STAT");
        write_ok(timer_addr(`TIMER_STAT_OFF), 32'h1);
        wait_irq_id(8'd1);
        check_eq("irq_req_o", 32'd1, data_t'(irq_req));
        write_ok(gpio_addr(`GPIO_IRQ_STAT_OFF), 32'h01);
        wait_irq_req(1'b0);

        // Decode errors, unmapped offsets and read-only writes
        m_load = 32'h33;
        write_ok(timer_addr(`TIMER_LOAD_OFF), m_load);
        wdata = $random(seed);
        expect_err(1'b1, addr_t'(2 << `APB_SLAVE_ADDR_WIDTH) | `GPIO_OUT_OFF, wdata);
        expect_err(1'b0, addr_t'(12'hF04), '0);
        wdata = $random(seed);
        expect_err(1'b1, gpio_addr(8'h10), wdata);
        expect_err(1'b0, timer_addr(8'h14), '0);
        wdata = $random(seed);
        expect_err(1'b1, gpio_addr(`GPIO_IN_OFF), wdata);
        wdata = $random(seed);
        expect_err(1'b1, timer_addr(`TIMER_COUNT_OFF), wdata);
        read_check(gpio_addr(`GPIO_OUT_OFF), data_t'(m_out), "GPIO OUT");
        read_check(gpio_addr(`GPIO_IRQ_EN_OFF), data_t'(m_en), "GPIO IRQ_EN");
        read_check(gpio_addr(`GPIO_IN_OFF), 32'h01, "GPIO IN");
        read_check(timer_addr(`TIMER_COUNT_OFF), m_load, "timer COUNT");
        read_check(timer_addr(`TIMER_LOAD_OFF), m_load, "timer LOAD");
        read_check(timer_addr(`TIMER_CTRL_OFF), 32'd0, "timer CTRL");

        if (u_dut.u_sva.err_cnt == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("Protocol assertions failed during the run");
            abort_run();
        end
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+src
src/soc_pkg.sv
src/irq_ctrl.sv
src/host_apb_bridge.sv
src/apb_gpio.sv
src/apb_timer.sv
src/soc_top.sv
test/tb_clk_gen.sv
test/soc_sva.sv
test/soc_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := soc_tb
FILELIST  := sim.f
SIMFLAGS  := --binary --timing --assert -Wno-fatal
LINTFLAGS := --lint-only --timing --assert
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "RESULT: PASS" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
